// ==== common/pwo_pkg.sv ====
// Modulus, widths, coefficient and word types, opcodes, command and memory request structs
package pwo_pkg;

    // ============================
    // Arithmetic constants
    // ============================
    localparam int COEFF_W = 23;
    localparam int SLOT_W  = 24;
    localparam int LANES   = 4;
    localparam int ADDR_W  = 15;
    localparam int MEM_W   = LANES * SLOT_W;

    localparam logic [COEFF_W-1:0] PWO_Q = 23'd8380417;

    // ============================
    // Data types
    // ============================
    typedef logic [COEFF_W-1:0]   coeff_t;
    typedef logic [2*COEFF_W-1:0] prod_t;

    // Four slots, top bit of each slot stays zero
    typedef logic [MEM_W-1:0]  mem_word_t;
    typedef logic [ADDR_W-1:0] mem_addr_t;

    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_op_t;

    // ============================
    // Command and memory ports
    // ============================
    typedef struct packed {
        pwo_op_t   op;
        logic      accumulate;
        mem_addr_t base_a;
        mem_addr_t base_b;
        mem_addr_t base_c;
    } pwo_cmd_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic      en;
        mem_addr_t addr;
        mem_word_t data;
    } mem_wr_t;

    // Per-word control that follows the data down the pipeline
    typedef struct packed {
        logic      valid;
        pwo_op_t   op;
        logic      accumulate;
        mem_addr_t idx;
    } lane_ctl_t;

endpackage

// ==== execute/pwo_mod_lane.sv ====
// Two-stage modular add, subtract and multiply-accumulate for one coefficient
`timescale 1ns/1ns

module pwo_mod_lane
    import pwo_pkg::*;
(
    input  logic    clk,
    input  logic    reset_n,
    input  pwo_op_t op_i,
    input  coeff_t  a_i,
    input  coeff_t  b_i,
    input  coeff_t  c_i,
    output coeff_t  res_o
);

    localparam logic [SLOT_W-1:0] Q_EXT = SLOT_W'(PWO_Q);

    // 2^23 is congruent to 2^13 - 1 modulo Q
    localparam int FOLD_SH = 13;

    logic [SLOT_W-1:0] sum_raw;
    coeff_t            diff_mod;
    coeff_t            sum_q;
    coeff_t            diff_q;
    coeff_t            c_q;
    prod_t             prod_q;
    pwo_op_t           op_q;
    logic [35:0]       fold1;
    logic [26:0]       fold2;
    logic [SLOT_W-1:0] fold3;
    coeff_t            prod_mod;
    logic [SLOT_W-1:0] acc_raw;
    coeff_t            res_q;

    // One conditional subtraction, input below 2Q
    function automatic coeff_t fix_q(input logic [SLOT_W-1:0] x);
        logic [SLOT_W-1:0] y;
        y = (x >= Q_EXT) ? (x - Q_EXT) : x;
        return coeff_t'(y);
    endfunction

    // ============================
    // Stage 1
    // ============================
    assign sum_raw = {1'b0, a_i} + {1'b0, b_i};

    // Adding Q back on a borrow stays inside 23 bits
    assign diff_mod = (a_i >= b_i) ? (a_i - b_i) : (a_i - b_i + PWO_Q);

    always_ff @(posedge clk) begin
        sum_q  <= fix_q(sum_raw);
        diff_q <= diff_mod;
        prod_q <= prod_t'(a_i) * prod_t'(b_i);
        c_q    <= c_i;
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            op_q <= pwm;
        end else begin
            op_q <= op_i;
        end
    end

    // ============================
    // Stage 2
    // ============================
    // Three folds bring the 46-bit product below 2Q
    assign fold1 = {prod_q[2*COEFF_W-1:COEFF_W], {FOLD_SH{1'b0}}}
                 - 36'(prod_q[2*COEFF_W-1:COEFF_W]) + 36'(prod_q[COEFF_W-1:0]);
    assign fold2 = 27'({fold1[35:COEFF_W], {FOLD_SH{1'b0}}})
                 - 27'(fold1[35:COEFF_W]) + 27'(fold1[COEFF_W-1:0]);
    assign fold3 = SLOT_W'({fold2[26:COEFF_W], {FOLD_SH{1'b0}}})
                 - SLOT_W'(fold2[26:COEFF_W]) + SLOT_W'(fold2[COEFF_W-1:0]);

    assign prod_mod = fix_q(fold3);
    assign acc_raw  = {1'b0, prod_mod} + {1'b0, c_q};

    always_ff @(posedge clk) begin
        case (op_q)
            pwa:     res_q <= sum_q;
            pws:     res_q <= diff_q;
            default: res_q <= fix_q(acc_raw);
        endcase
    end

    assign res_o = res_q;

    a_res_reduced: assert property (
        @(posedge clk) disable iff (!reset_n)
        res_o < PWO_Q
    );

endmodule

// ==== execute/pwo_execute.sv ====
// Word unpacking, four modular lanes and the matching control delay line
`timescale 1ns/1ns

module pwo_execute
    import pwo_pkg::*;
(
    input  logic               clk,
    input  logic               reset_n,
    input  lane_ctl_t          ctl_i,
    input  mem_word_t          a_i,
    input  mem_word_t          b_i,
    input  mem_word_t          c_i,
    output lane_ctl_t          ctl_o,
    output coeff_t [LANES-1:0] res_o
);

    coeff_t [LANES-1:0] a_lane;
    coeff_t [LANES-1:0] b_lane;
    coeff_t [LANES-1:0] c_lane;
    lane_ctl_t          ctl_q1;
    lane_ctl_t          ctl_q2;
    logic               use_c;

    // Accumulator word is only meaningful for pwm with accumulate
    assign use_c = ctl_i.valid && ctl_i.accumulate && (ctl_i.op == pwm);

    // ============================
    // Slot unpacking
    // ============================
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            // Idle cycles feed zeros so the lanes stay at known values
            a_lane[k] = ctl_i.valid ? a_i[k*SLOT_W +: COEFF_W] : '0;
            b_lane[k] = ctl_i.valid ? b_i[k*SLOT_W +: COEFF_W] : '0;
            c_lane[k] = use_c ? c_i[k*SLOT_W +: COEFF_W] : '0;
        end
    end

    for (genvar g = 0; g < LANES; g++) begin : g_lane
        pwo_mod_lane i_pwo_mod_lane (
            .clk    (clk),
            .reset_n(reset_n),
            .op_i   (ctl_i.op),
            .a_i    (a_lane[g]),
            .b_i    (b_lane[g]),
            .c_i    (c_lane[g]),
            .res_o  (res_o[g])
        );
    end

    // Two stages, same as the lane pipeline
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ctl_q1 <= '0;
            ctl_q2 <= '0;
        end else begin
            ctl_q1 <= ctl_i;
            ctl_q2 <= ctl_q1;
        end
    end

    assign ctl_o = ctl_q2;

endmodule

// ==== src/pwo_decode.sv ====
// Command handshake, sequencing FSM, read address generation and per-word control
`timescale 1ns/1ns

module pwo_decode
    import pwo_pkg::*;
#(
    parameter int NUM_WORDS = 64
)
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      cmd_valid_i,
    input  pwo_cmd_t  cmd_i,
    output logic      cmd_ready_o,
    output mem_req_t  rd_a_o,
    output mem_req_t  rd_b_o,
    output mem_req_t  rd_c_o,
    output lane_ctl_t ctl_o,
    output mem_addr_t base_c_o,
    input  logic      last_i,
    output logic      busy_o
);

    localparam mem_addr_t LAST_IDX = mem_addr_t'(NUM_WORDS - 1);

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } state_t;

    state_t    state;
    pwo_cmd_t  cmd_q;
    mem_addr_t word_cnt;
    logic      cmd_fire;
    logic      issue;
    logic      use_c;

    assign cmd_ready_o = (state == IDLE);
    assign cmd_fire    = cmd_valid_i && cmd_ready_o;
    assign issue       = (state == ISSUE);
    assign busy_o      = (state != IDLE);

    // Only pwm with accumulate reads the destination
    assign use_c = (cmd_q.op == pwm) && cmd_q.accumulate;

    // ============================
    // Sequencing FSM
    // ============================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (cmd_fire) begin
                        state    <= ISSUE;
                        word_cnt <= '0;
                    end
                end
                ISSUE: begin
                    if (word_cnt == LAST_IDX) begin
                        state <= DRAIN;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                DRAIN: begin
                    // Wait for the last write to leave result
                    if (last_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Latched command, held until the next handshake
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            cmd_q <= '0;
        end else if (cmd_fire) begin
            cmd_q <= cmd_i;
        end
    end

    assign base_c_o = cmd_q.base_c;

    // ============================
    // Read requests
    // ============================
    assign rd_a_o = '{en: issue, addr: cmd_q.base_a + word_cnt};
    assign rd_b_o = '{en: issue, addr: cmd_q.base_b + word_cnt};
    assign rd_c_o = '{en: issue && use_c, addr: cmd_q.base_c + word_cnt};

    // Control lines up with the read data one cycle later
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ctl_o <= '0;
        end else if (issue) begin
            ctl_o <= '{valid: 1'b1, op: cmd_q.op, accumulate: cmd_q.accumulate, idx: word_cnt};
        end else begin
            ctl_o <= '0;
        end
    end

    // Read requests stay inside the polynomial window
    a_rd_in_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        (rd_a_o.en || rd_b_o.en || rd_c_o.en) |-> (word_cnt <= LAST_IDX)
    );

endmodule

// ==== src/pwo_result.sv ====
// Result packing, destination write register, last-write flag and done pulse
`timescale 1ns/1ns

module pwo_result
    import pwo_pkg::*;
#(
    parameter int NUM_WORDS = 64
)
(
    input  logic               clk,
    input  logic               reset_n,
    input  lane_ctl_t          ctl_i,
    input  coeff_t [LANES-1:0] res_i,
    input  mem_addr_t          base_c_i,
    output mem_wr_t            wr_o,
    output logic               last_o,
    output logic               done_o
);

    localparam mem_addr_t LAST_IDX = mem_addr_t'(NUM_WORDS - 1);

    mem_word_t packed_word;
    logic      wr_en_q;
    mem_addr_t wr_addr_q;
    mem_word_t wr_data_q;

    // Zero-padded 24-bit slots
    always_comb begin
        packed_word = '0;
        for (int k = 0; k < LANES; k++) begin
            packed_word[k*SLOT_W +: COEFF_W] = res_i[k];
        end
    end

    // ============================
    // Write and completion
    // ============================
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_en_q <= 1'b0;
            last_o  <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            wr_en_q <= ctl_i.valid;
            last_o  <= ctl_i.valid && (ctl_i.idx == LAST_IDX);
            // Done follows the last write by one cycle
            done_o  <= last_o;
        end
    end

    always_ff @(posedge clk) begin
        wr_addr_q <= base_c_i + ctl_i.idx;
        wr_data_q <= packed_word;
    end

    assign wr_o = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};

    a_done_single: assert property (
        @(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o
    );

endmodule

// ==== src/pwo_top.sv ====
// Pointwise polynomial engine top level with command, memory read and write ports
`timescale 1ns/1ns

module pwo_top
    import pwo_pkg::*;
#(
    parameter int NUM_WORDS = 64
)
(
    input  logic      clk,
    input  logic      reset_n,

    // Command handshake
    input  logic      cmd_valid_i,
    output logic      cmd_ready_o,
    input  pwo_cmd_t  cmd_i,

    // Operand and accumulator reads
    output mem_req_t  rd_a_o,
    output mem_req_t  rd_b_o,
    output mem_req_t  rd_c_o,
    input  mem_word_t rd_a_data_i,
    input  mem_word_t rd_b_data_i,
    input  mem_word_t rd_c_data_i,

    // Destination write
    output mem_wr_t   wr_o,

    output logic      busy_o,
    output logic      done_o
);

    lane_ctl_t          dec_ctl;
    lane_ctl_t          exe_ctl;
    coeff_t [LANES-1:0] exe_res;
    mem_addr_t          base_c;
    logic               last_wr;

    pwo_decode #(
        .NUM_WORDS(NUM_WORDS)
    ) i_pwo_decode (
        .clk        (clk),
        .reset_n    (reset_n),
        .cmd_valid_i(cmd_valid_i),
        .cmd_i      (cmd_i),
        .cmd_ready_o(cmd_ready_o),
        .rd_a_o     (rd_a_o),
        .rd_b_o     (rd_b_o),
        .rd_c_o     (rd_c_o),
        .ctl_o      (dec_ctl),
        .base_c_o   (base_c),
        .last_i     (last_wr),
        .busy_o     (busy_o)
    );

    pwo_execute i_pwo_execute (
        .clk    (clk),
        .reset_n(reset_n),
        .ctl_i  (dec_ctl),
        .a_i    (rd_a_data_i),
        .b_i    (rd_b_data_i),
        .c_i    (rd_c_data_i),
        .ctl_o  (exe_ctl),
        .res_o  (exe_res)
    );

    pwo_result #(
        .NUM_WORDS(NUM_WORDS)
    ) i_pwo_result (
        .clk     (clk),
        .reset_n (reset_n),
        .ctl_i   (exe_ctl),
        .res_i   (exe_res),
        .base_c_i(base_c),
        .wr_o    (wr_o),
        .last_o  (last_wr),
        .done_o  (done_o)
    );

endmodule

// ==== test/pwo_tb_mem.sv ====
// Behavioral A, B and C memories with one-cycle reads, a C write port and a preload port
`timescale 1ns/1ns

module pwo_tb_mem
    import pwo_pkg::*;
#(
    parameter int DEPTH = 256
)
(
    input  logic      clk,
    input  mem_req_t  rd_a_i,
    input  mem_req_t  rd_b_i,
    input  mem_req_t  rd_c_i,
    output mem_word_t rd_a_data_o,
    output mem_word_t rd_b_data_o,
    output mem_word_t rd_c_data_o,
    input  mem_wr_t   wr_i,
    // Preload writes the same address of all three memories
    input  logic      load_en_i,
    input  mem_addr_t load_addr_i,
    input  mem_word_t load_a_i,
    input  mem_word_t load_b_i,
    input  mem_word_t load_c_i
);

    localparam int IDX_W = $clog2(DEPTH);

    mem_word_t mem_a [DEPTH];
    mem_word_t mem_b [DEPTH];
    mem_word_t mem_c [DEPTH];

    // Read data holds while the enable is low
    always_ff @(posedge clk) begin
        if (rd_a_i.en) rd_a_data_o <= mem_a[rd_a_i.addr[IDX_W-1:0]];
        if (rd_b_i.en) rd_b_data_o <= mem_b[rd_b_i.addr[IDX_W-1:0]];
        if (rd_c_i.en) rd_c_data_o <= mem_c[rd_c_i.addr[IDX_W-1:0]];
    end

    always_ff @(posedge clk) begin
        if (load_en_i) begin
            mem_a[load_addr_i[IDX_W-1:0]] <= load_a_i;
            mem_b[load_addr_i[IDX_W-1:0]] <= load_b_i;
            mem_c[load_addr_i[IDX_W-1:0]] <= load_c_i;
        end else if (wr_i.en) begin
            mem_c[wr_i.addr[IDX_W-1:0]] <= wr_i.data;
        end
    end

endmodule

// ==== test/pwo_tb.sv ====
// Testbench with clock, reset, command table, golden model, write monitor and watchdog
`timescale 1ns/1ns

module pwo_tb
    import pwo_pkg::*;
();

    localparam int NUM_WORDS = 64;
    localparam int DEPTH     = 256;
    localparam int NUM_CMDS  = 5;
    localparam int WATCHDOG_CYCLES = DEPTH + 40 + NUM_CMDS * (NUM_WORDS + 20);
    localparam longint unsigned QL = 64'(PWO_Q);

    typedef struct packed {
        pwo_cmd_t cmd;
        logic     reads_c;
    } cmd_row_t;

    logic      clk = 1'b0;
    logic      reset_n;
    logic      cmd_valid;
    logic      cmd_ready;
    pwo_cmd_t  cmd;
    mem_req_t  rd_a, rd_b, rd_c;
    mem_word_t rd_a_data, rd_b_data, rd_c_data;
    mem_wr_t   wr;
    logic      busy;
    logic      done;
    logic      load_en;
    mem_addr_t load_addr;
    mem_word_t load_a, load_b, load_c;

    mem_word_t   model_a [DEPTH];
    mem_word_t   model_b [DEPTH];
    mem_word_t   model_c [DEPTH];
    cmd_row_t    cmd_table [NUM_CMDS];
    cmd_row_t    cur_row;
    int unsigned cycle = 0;
    int unsigned last_wr_cycle = 0;
    int unsigned rd_cycles [$];
    int          wr_count = 0;
    int          wr_total = 0;
    int          rd_count = 0;
    int          done_count = 0;
    int          errors = 0;
    int          n_checks = 0;
    logic        busy_exp = 1'b0;
    logic        rd_exp;

    pwo_top #(.NUM_WORDS(NUM_WORDS)) i_pwo_top (
        .clk(clk), .reset_n(reset_n),
        .cmd_valid_i(cmd_valid), .cmd_ready_o(cmd_ready), .cmd_i(cmd),
        .rd_a_o(rd_a), .rd_b_o(rd_b), .rd_c_o(rd_c),
        .rd_a_data_i(rd_a_data), .rd_b_data_i(rd_b_data), .rd_c_data_i(rd_c_data),
        .wr_o(wr), .busy_o(busy), .done_o(done)
    );

    pwo_tb_mem #(.DEPTH(DEPTH)) i_mem (
        .clk(clk), .rd_a_i(rd_a), .rd_b_i(rd_b), .rd_c_i(rd_c),
        .rd_a_data_o(rd_a_data), .rd_b_data_o(rd_b_data), .rd_c_data_o(rd_c_data),
        .wr_i(wr), .load_en_i(load_en), .load_addr_i(load_addr),
        .load_a_i(load_a), .load_b_i(load_b), .load_c_i(load_c)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        n_checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic mem_word_t random_word();
        mem_word_t w;
        w = '0;
        for (int k = 0; k < LANES; k++) begin
            w[k*SLOT_W +: COEFF_W] = coeff_t'(64'($urandom) % QL);
        end
        return w;
    endfunction

    // Reference arithmetic per coefficient, accumulate only counts for pwm
    function automatic mem_word_t expected_word(input pwo_cmd_t c, input mem_word_t wa,
                                                input mem_word_t wb, input mem_word_t wc);
        longint unsigned a;
        longint unsigned b;
        longint unsigned acc;
        longint unsigned r;
        mem_word_t       w;
        w = '0;
        for (int k = 0; k < LANES; k++) begin
            a   = 64'(wa[k*SLOT_W +: COEFF_W]);
            b   = 64'(wb[k*SLOT_W +: COEFF_W]);
            acc = c.accumulate ? 64'(wc[k*SLOT_W +: COEFF_W]) : 64'd0;
            case (c.op)
                pwa:     r = (a + b) % QL;
                pws:     r = (a + QL - b) % QL;
                default: r = (a * b + acc) % QL;
            endcase
            w[k*SLOT_W +: COEFF_W] = coeff_t'(r);
        end
        return w;
    endfunction

    function automatic void update_model(input pwo_cmd_t c);
        for (int i = 0; i < NUM_WORDS; i++) begin
            model_c[int'(c.base_c) + i] = expected_word(c, model_a[int'(c.base_a) + i],
                                                        model_b[int'(c.base_b) + i],
                                                        model_c[int'(c.base_c) + i]);
        end
    endfunction

    task automatic load_memories();
        for (int i = 0; i < DEPTH; i++) begin
            model_a[i] = random_word();
            model_b[i] = random_word();
            model_c[i] = random_word();
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = mem_addr_t'(i);
            load_a    = model_a[i];
            load_b    = model_b[i];
            load_c    = model_c[i];
        end
        @(posedge clk);
        #1;
        load_en = 1'b0;
    endtask

    // ==============================
    // Write and timing monitor
    // ==============================
    always @(negedge clk) begin
        if (reset_n) begin
            // Busy ends in the done cycle, ready comes back with it
            if (done) begin
                busy_exp = 1'b0;
            end
            check_equal(busy, busy_exp, "busy");
            check_equal(cmd_ready, !busy_exp, "command ready");

            // Reads run for NUM_WORDS cycles right after the handshake
            rd_exp = busy_exp && (rd_count < NUM_WORDS);
            check_equal(rd_a.en, rd_exp, "A read enable");
            check_equal(rd_b.en, rd_exp, "B read enable");
            check_equal(rd_c.en, rd_exp && cur_row.reads_c, "C read enable");
            if (rd_a.en) begin
                rd_cycles.push_back(cycle);
                check_equal(rd_a.addr, mem_addr_t'(int'(cur_row.cmd.base_a) + rd_count),
                            "A read address");
            end
            if (rd_b.en) begin
                check_equal(rd_b.addr, mem_addr_t'(int'(cur_row.cmd.base_b) + rd_count),
                            "B read address");
            end
            if (rd_c.en) begin
                check_equal(rd_c.addr, mem_addr_t'(int'(cur_row.cmd.base_c) + rd_count),
                            "C read address");
            end
            if (rd_exp) begin
                rd_count++;
            end

            if (wr.en) begin
                if (rd_cycles.size() == 0) begin
                    errors++;
                    $display("A write came without a matching read request at %0t ns", $time);
                end else begin
                    check_equal(cycle - rd_cycles.pop_front(), 4, "write latency");
                end
                check_equal(wr.addr, mem_addr_t'(int'(cur_row.cmd.base_c) + wr_count),
                            "write address");
                check_equal(wr.data, model_c[int'(cur_row.cmd.base_c) + wr_count],
                            "write data");
                last_wr_cycle = cycle;
                wr_count++;
                wr_total++;
            end
            if (done) begin
                check_equal(cycle - last_wr_cycle, 1, "done after last write");
                check_equal(wr_count, NUM_WORDS, "writes per command");
                done_count++;
                wr_count = 0;
            end

            // Handshake at the next rising edge
            if (cmd_valid && cmd_ready) begin
                busy_exp = 1'b1;
                rd_count = 0;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 4);
        $display("Timeout after %0d cycles, the commands did not complete", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        void'($urandom(32'h92ad));
        reset_n   = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_a    = '0;
        load_b    = '0;
        load_c    = '0;
        cur_row   = '0;
        // Columns: op, accumulate, base_a, base_b, base_c, then expected C read
        cmd_table[0] = '{'{pwa, 1'b0, 15'd0, 15'd64, 15'd128}, 1'b0};
        cmd_table[1] = '{'{pws, 1'b1, 15'd64, 15'd0, 15'd192}, 1'b0};
        cmd_table[2] = '{'{pwm, 1'b0, 15'd0, 15'd64, 15'd128}, 1'b0};
        cmd_table[3] = '{'{pwm, 1'b1, 15'd64, 15'd128, 15'd128}, 1'b1};
        cmd_table[4] = '{'{pwm, 1'b1, 15'd64, 15'd128, 15'd128}, 1'b1};
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(negedge clk);
        check_equal(cmd_ready, 1'b1, "ready after reset");
        check_equal({busy, done, rd_a.en, rd_b.en, rd_c.en, wr.en}, '0, "idle after reset");
        load_memories();

        // Each command stays valid from the previous handshake until accepted
        for (int k = 0; k < NUM_CMDS; k++) begin
            cmd_valid = 1'b1;
            cmd       = cmd_table[k].cmd;
            @(negedge clk);
            while (!cmd_ready) @(negedge clk);
            if (k > 0) check_equal(done, 1'b1, "accept on done pulse");
            cur_row = cmd_table[k];
            update_model(cmd_table[k].cmd);
            @(posedge clk);
            #1;
        end
        cmd_valid = 1'b0;
        @(negedge clk);
        while (!done) @(negedge clk);
        repeat (4) @(posedge clk);

        for (int i = 0; i < DEPTH; i++) begin
            check_equal(i_mem.mem_c[i], model_c[i], "final C memory");
        end
        check_equal(done_count, NUM_CMDS, "done pulse count");
        check_equal(wr_total, NUM_CMDS * NUM_WORDS, "total writes");
        $display("Checks: %0d, errors: %0d", n_checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
common/pwo_pkg.sv
execute/pwo_mod_lane.sv
execute/pwo_execute.sv
src/pwo_decode.sv
src/pwo_result.sv
src/pwo_top.sv
test/pwo_tb_mem.sv
test/pwo_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f flist.f --top-module pwo_tb -o pwo_tb_sim
sim_out=$(./obj_dir/pwo_tb_sim)
echo "$sim_out"

if ! echo "$sim_out" | grep -qx "Finished with no errors"; then
    exit 1
fi
